//--- source/dmem_pkg.sv
package dmem_pkg;

  //////////////////////////////////////////////////////////////////////
  // word geometry
  //////////////////////////////////////////////////////////////////////

  localparam int data_width_gp = 32;

  // one enable per byte lane
  localparam int mask_width_gp = data_width_gp / 8;

  localparam int pc_width_gp = 32;

  // widest word index the remote address views can carry
  localparam int max_addr_width_gp = 14;

  //////////////////////////////////////////////////////////////////////
  // data types
  //////////////////////////////////////////////////////////////////////

  typedef logic [data_width_gp-1:0] dmem_word_t;

  typedef logic [mask_width_gp-1:0] dmem_mask_t;

  typedef logic [pc_width_gp-1:0] pc_t;

  // local core request kind
  typedef enum logic {
    local_load  = 1'b0,
    local_store = 1'b1
  } local_op_e;

endpackage

//--- source/remote_map_pkg.sv
package remote_map_pkg;

  //////////////////////////////////////////////////////////////////////
  // region codes, top bit of the wishbone byte address
  //////////////////////////////////////////////////////////////////////

  localparam logic region_dmem_gc    = 1'b0;
  localparam logic region_tracker_gc = 1'b1;

  // bits between the region bit and the word index
  localparam int addr_pad_width_gp = 32 - 1 - dmem_pkg::max_addr_width_gp - 2;

  // data memory view, byte offset ignored
  typedef struct packed {
    logic                                   region;
    logic [addr_pad_width_gp-1:0]           unused;
    logic [dmem_pkg::max_addr_width_gp-1:0] word_idx;
    logic [1:0]                             byte_off;
  } dmem_view_s;

  // tracker table view, one pc per word
  typedef struct packed {
    logic                                   region;
    logic [addr_pad_width_gp-1:0]           unused;
    logic [dmem_pkg::max_addr_width_gp-1:0] entry_idx;
    logic [1:0]                             zero;
  } tracker_view_s;

  // region bit picks the view
  typedef union packed {
    dmem_view_s    dmem;
    tracker_view_s trk;
  } remote_addr_u;

endpackage

//--- source/wb_remote_port.sv
`timescale 1ns/10ps

module wb_remote_port #(
  parameter int addr_width_p = 8
) (
  input  logic                         clk_i,
  input  logic                         reset_i,

  // wishbone classic slave
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  remote_map_pkg::remote_addr_u wb_adr_i,
  input  dmem_pkg::dmem_mask_t         wb_sel_i,
  input  dmem_pkg::dmem_word_t         wb_dat_i,
  output logic                         wb_ack_o,
  output dmem_pkg::dmem_word_t         wb_dat_o,

  // request to the arbiter
  output logic                         rem_v_o,
  output logic                         rem_w_o,
  output logic                         rem_region_o,
  output logic [addr_width_p-1:0]      rem_addr_o,
  output dmem_pkg::dmem_mask_t         rem_mask_o,
  output dmem_pkg::dmem_word_t         rem_data_o,
  input  logic                         rem_done_i,
  input  dmem_pkg::dmem_word_t         rem_rdata_i
);

  logic                 pend_r;
  dmem_pkg::dmem_word_t dat_r;

  // region bit and index sit at the same place in both views
  assign rem_region_o = wb_adr_i.dmem.region;
  assign rem_addr_o   = wb_adr_i.dmem.word_idx[addr_width_p-1:0];

  // one request per strobe, none while the ack is out
  assign rem_v_o    = wb_cyc_i & wb_stb_i & ~pend_r;
  assign rem_w_o    = wb_we_i;
  assign rem_mask_o = wb_sel_i;
  assign rem_data_o = wb_dat_i;

  // ack follows the grant by one cycle
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      pend_r <= 1'b0;
    end else begin
      pend_r <= rem_v_o;
    end
  end

  // hold the last read word after the ack
  always_ff @(posedge clk_i) begin
    if (rem_done_i) begin
      dat_r <= rem_rdata_i;
    end
  end

  assign wb_ack_o = pend_r;
  assign wb_dat_o = rem_done_i ? rem_rdata_i : dat_r;

endmodule

//--- source/local_req_fifo.sv
`timescale 1ns/10ps

module local_req_fifo #(
  parameter int addr_width_p = 8,
  parameter int fifo_depth_p = 4
) (
  input  logic                    clk_i,
  input  logic                    reset_i,

  // core side
  input  logic                    local_v_i,
  input  dmem_pkg::local_op_e     local_op_i,
  input  logic [addr_width_p-1:0] local_addr_i,
  input  dmem_pkg::dmem_mask_t    local_mask_i,
  input  dmem_pkg::dmem_word_t    local_data_i,
  input  dmem_pkg::pc_t           local_pc_i,
  output logic                    local_ready_o,

  // head of queue
  output logic                    q_v_o,
  output dmem_pkg::local_op_e     q_op_o,
  output logic [addr_width_p-1:0] q_addr_o,
  output dmem_pkg::dmem_mask_t    q_mask_o,
  output dmem_pkg::dmem_word_t    q_data_o,
  output dmem_pkg::pc_t           q_pc_o,
  input  logic                    q_yumi_i
);

  localparam int ptr_width_lp = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;
  localparam int cnt_width_lp = $clog2(fifo_depth_p + 1);

  dmem_pkg::local_op_e     op_mem   [fifo_depth_p];
  logic [addr_width_p-1:0] addr_mem [fifo_depth_p];
  dmem_pkg::dmem_mask_t    mask_mem [fifo_depth_p];
  dmem_pkg::dmem_word_t    data_mem [fifo_depth_p];
  dmem_pkg::pc_t           pc_mem   [fifo_depth_p];

  logic [ptr_width_lp-1:0] wptr_r;
  logic [ptr_width_lp-1:0] rptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    push;
  logic                    pop;

  // wrap at depth, which need not be a power of two
  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    if (ptr == ptr_width_lp'(fifo_depth_p - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign local_ready_o = (count_r != cnt_width_lp'(fifo_depth_p));
  assign q_v_o         = (count_r != '0);
  assign push          = local_v_i & local_ready_o;
  assign pop           = q_yumi_i & q_v_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_mem[wptr_r]   <= local_op_i;
      addr_mem[wptr_r] <= local_addr_i;
      mask_mem[wptr_r] <= local_mask_i;
      data_mem[wptr_r] <= local_data_i;
      pc_mem[wptr_r]   <= local_pc_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (push) begin
        wptr_r <= next_ptr(wptr_r);
      end
      if (pop) begin
        rptr_r <= next_ptr(rptr_r);
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  assign q_op_o   = op_mem[rptr_r];
  assign q_addr_o = addr_mem[rptr_r];
  assign q_mask_o = mask_mem[rptr_r];
  assign q_data_o = data_mem[rptr_r];
  assign q_pc_o   = pc_mem[rptr_r];

endmodule

//--- source/dmem_arbiter.sv
`timescale 1ns/10ps

module dmem_arbiter #(
  parameter int addr_width_p = 8
) (
  input  logic                    clk_i,
  input  logic                    reset_i,

  // remote requester, never stalled
  input  logic                    rem_v_i,
  input  logic                    rem_w_i,
  input  logic                    rem_region_i,
  input  logic [addr_width_p-1:0] rem_addr_i,
  input  dmem_pkg::dmem_mask_t    rem_mask_i,
  input  dmem_pkg::dmem_word_t    rem_data_i,
  output logic                    rem_done_o,
  output dmem_pkg::dmem_word_t    rem_rdata_o,

  // local queue head
  input  logic                    q_v_i,
  input  dmem_pkg::local_op_e     q_op_i,
  input  logic [addr_width_p-1:0] q_addr_i,
  input  dmem_pkg::dmem_mask_t    q_mask_i,
  input  dmem_pkg::dmem_word_t    q_data_i,
  input  dmem_pkg::pc_t           q_pc_i,
  output logic                    q_yumi_o,

  // data memory
  output logic                    mem_en_o,
  output logic                    mem_we_o,
  output logic [addr_width_p-1:0] mem_addr_o,
  output dmem_pkg::dmem_mask_t    mem_mask_o,
  output dmem_pkg::dmem_word_t    mem_wdata_o,
  input  dmem_pkg::dmem_word_t    mem_rdata_i,

  // write tracker
  output logic                    trk_rec_v_o,
  output dmem_pkg::pc_t           trk_pc_o,
  output logic                    trk_rd_v_o,
  output logic [addr_width_p-1:0] trk_rd_addr_o,
  input  dmem_pkg::pc_t           trk_rdata_i,

  // local load return
  output logic                    local_rdata_v_o,
  output dmem_pkg::dmem_word_t    local_rdata_o
);

  logic rem_trk;
  logic local_grant;
  logic local_st;
  logic rem_done_r;
  logic rd_trk_r;
  logic local_rd_r;

  // remote always wins
  assign rem_trk     = (rem_region_i == remote_map_pkg::region_tracker_gc);
  assign local_grant = q_v_i & ~rem_v_i;
  assign local_st    = (q_op_i == dmem_pkg::local_store);
  assign q_yumi_o    = local_grant;

  assign mem_en_o    = (rem_v_i & ~rem_trk) | local_grant;
  assign mem_we_o    = rem_v_i ? rem_w_i : local_st;
  assign mem_addr_o  = rem_v_i ? rem_addr_i : q_addr_i;
  assign mem_mask_o  = rem_v_i ? rem_mask_i : q_mask_i;
  assign mem_wdata_o = rem_v_i ? rem_data_i : q_data_i;

  // only local stores are tracked
  assign trk_rec_v_o   = local_grant & local_st;
  assign trk_pc_o      = q_pc_i;
  assign trk_rd_v_o    = rem_v_i & rem_trk & ~rem_w_i;
  assign trk_rd_addr_o = rem_addr_i;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      rem_done_r <= 1'b0;
      local_rd_r <= 1'b0;
    end else begin
      rem_done_r <= rem_v_i;
      local_rd_r <= local_grant & ~local_st;
    end
  end

  // source of the read data one cycle on
  always_ff @(posedge clk_i) begin
    rd_trk_r <= rem_trk;
  end

  assign rem_done_o      = rem_done_r;
  assign rem_rdata_o     = rd_trk_r ? dmem_pkg::dmem_word_t'(trk_rdata_i) : mem_rdata_i;
  assign local_rdata_v_o = local_rd_r;
  assign local_rdata_o   = mem_rdata_i;

endmodule

//--- source/dmem_bank.sv
`timescale 1ns/10ps

module dmem_bank #(
  parameter int addr_width_p = 8
) (
  input  logic                    clk_i,
  input  logic                    en_i,
  input  logic                    we_i,
  input  logic [addr_width_p-1:0] addr_i,
  input  dmem_pkg::dmem_mask_t    mask_i,
  input  dmem_pkg::dmem_word_t    wdata_i,
  output dmem_pkg::dmem_word_t    rdata_o
);

  localparam int words_lp = 2 ** addr_width_p;

  dmem_pkg::dmem_word_t mem_r [words_lp];

  //////////////////////////////////////////////////////////////////////
  // single port, write or read per cycle
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      // byte lanes
      for (int i = 0; i < dmem_pkg::mask_width_gp; i++) begin
        if (mask_i[i]) begin
          mem_r[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // read data valid the cycle after the access
  always_ff @(posedge clk_i) begin
    if (en_i && !we_i) begin
      rdata_o <= mem_r[addr_i];
    end
  end

endmodule

//--- source/dmem_write_tracker.sv
`timescale 1ns/10ps

module dmem_write_tracker #(
  parameter int addr_width_p = 8
) (
  input  logic                    clk_i,
  input  logic                    reset_i,

  // record from a local store
  input  logic                    rec_v_i,
  input  logic [addr_width_p-1:0] rec_addr_i,
  input  dmem_pkg::pc_t           rec_pc_i,

  // remote lookup
  input  logic                    rd_v_i,
  input  logic [addr_width_p-1:0] rd_addr_i,
  output dmem_pkg::pc_t           rd_pc_o
);

  localparam int entries_lp = 2 ** addr_width_p;

  dmem_pkg::pc_t           pc_mem [entries_lp];
  logic [entries_lp-1:0]   written_r;

  // last writer's pc per word
  always_ff @(posedge clk_i) begin
    if (rec_v_i) begin
      pc_mem[rec_addr_i] <= rec_pc_i;
    end
  end

  // written flags, cleared by reset
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      written_r <= '0;
    end else if (rec_v_i) begin
      written_r[rec_addr_i] <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // registered lookup
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      if (written_r[rd_addr_i]) begin
        rd_pc_o <= pc_mem[rd_addr_i];
      end else begin
        // never stored to locally
        rd_pc_o <= '0;
      end
    end
  end

endmodule

//--- source/dmem_tile_top.sv
`timescale 1ns/10ps

module dmem_tile_top #(
  parameter int addr_width_p = 8,
  parameter int fifo_depth_p = 4
) (
  input  logic                         clk_i,
  input  logic                         reset_i,

  // network side
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  remote_map_pkg::remote_addr_u wb_adr_i,
  input  dmem_pkg::dmem_mask_t         wb_sel_i,
  input  dmem_pkg::dmem_word_t         wb_dat_i,
  output logic                         wb_ack_o,
  output dmem_pkg::dmem_word_t         wb_dat_o,

  // core side
  input  logic                         local_v_i,
  input  dmem_pkg::local_op_e          local_op_i,
  input  logic [addr_width_p-1:0]      local_addr_i,
  input  dmem_pkg::dmem_mask_t         local_mask_i,
  input  dmem_pkg::dmem_word_t         local_data_i,
  input  dmem_pkg::pc_t                local_pc_i,
  output logic                         local_ready_o,
  output logic                         local_rdata_v_o,
  output dmem_pkg::dmem_word_t         local_rdata_o
);

  // remote path
  logic                    rem_v;
  logic                    rem_w;
  logic                    rem_region;
  logic [addr_width_p-1:0] rem_addr;
  dmem_pkg::dmem_mask_t    rem_mask;
  dmem_pkg::dmem_word_t    rem_data;
  logic                    rem_done;
  dmem_pkg::dmem_word_t    rem_rdata;

  // queue head
  logic                    q_v;
  dmem_pkg::local_op_e     q_op;
  logic [addr_width_p-1:0] q_addr;
  dmem_pkg::dmem_mask_t    q_mask;
  dmem_pkg::dmem_word_t    q_data;
  dmem_pkg::pc_t           q_pc;
  logic                    q_yumi;

  // memory and tracker
  logic                    mem_en;
  logic                    mem_we;
  logic [addr_width_p-1:0] mem_addr;
  dmem_pkg::dmem_mask_t    mem_mask;
  dmem_pkg::dmem_word_t    mem_wdata;
  dmem_pkg::dmem_word_t    mem_rdata;
  logic                    trk_rec_v;
  dmem_pkg::pc_t           trk_pc;
  logic                    trk_rd_v;
  logic [addr_width_p-1:0] trk_rd_addr;
  dmem_pkg::pc_t           trk_rdata;

  //////////////////////////////////////////////////////////////////////
  // producer, buffer, consumer
  //////////////////////////////////////////////////////////////////////

  wb_remote_port #(
    .addr_width_p(addr_width_p)
  ) remote_port (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_sel_i     (wb_sel_i),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_o     (wb_ack_o),
    .wb_dat_o     (wb_dat_o),
    .rem_v_o      (rem_v),
    .rem_w_o      (rem_w),
    .rem_region_o (rem_region),
    .rem_addr_o   (rem_addr),
    .rem_mask_o   (rem_mask),
    .rem_data_o   (rem_data),
    .rem_done_i   (rem_done),
    .rem_rdata_i  (rem_rdata)
  );

  local_req_fifo #(
    .addr_width_p(addr_width_p),
    .fifo_depth_p(fifo_depth_p)
  ) req_fifo (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .local_v_i     (local_v_i),
    .local_op_i    (local_op_i),
    .local_addr_i  (local_addr_i),
    .local_mask_i  (local_mask_i),
    .local_data_i  (local_data_i),
    .local_pc_i    (local_pc_i),
    .local_ready_o (local_ready_o),
    .q_v_o         (q_v),
    .q_op_o        (q_op),
    .q_addr_o      (q_addr),
    .q_mask_o      (q_mask),
    .q_data_o      (q_data),
    .q_pc_o        (q_pc),
    .q_yumi_i      (q_yumi)
  );

  dmem_arbiter #(
    .addr_width_p(addr_width_p)
  ) arbiter (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .rem_v_i         (rem_v),
    .rem_w_i         (rem_w),
    .rem_region_i    (rem_region),
    .rem_addr_i      (rem_addr),
    .rem_mask_i      (rem_mask),
    .rem_data_i      (rem_data),
    .rem_done_o      (rem_done),
    .rem_rdata_o     (rem_rdata),
    .q_v_i           (q_v),
    .q_op_i          (q_op),
    .q_addr_i        (q_addr),
    .q_mask_i        (q_mask),
    .q_data_i        (q_data),
    .q_pc_i          (q_pc),
    .q_yumi_o        (q_yumi),
    .mem_en_o        (mem_en),
    .mem_we_o        (mem_we),
    .mem_addr_o      (mem_addr),
    .mem_mask_o      (mem_mask),
    .mem_wdata_o     (mem_wdata),
    .mem_rdata_i     (mem_rdata),
    .trk_rec_v_o     (trk_rec_v),
    .trk_pc_o        (trk_pc),
    .trk_rd_v_o      (trk_rd_v),
    .trk_rd_addr_o   (trk_rd_addr),
    .trk_rdata_i     (trk_rdata),
    .local_rdata_v_o (local_rdata_v_o),
    .local_rdata_o   (local_rdata_o)
  );

  dmem_bank #(
    .addr_width_p(addr_width_p)
  ) bank (
    .clk_i   (clk_i),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .mask_i  (mem_mask),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  // records use the memory address of the store
  dmem_write_tracker #(
    .addr_width_p(addr_width_p)
  ) tracker (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rec_v_i    (trk_rec_v),
    .rec_addr_i (mem_addr),
    .rec_pc_i   (trk_pc),
    .rd_v_i     (trk_rd_v),
    .rd_addr_i  (trk_rd_addr),
    .rd_pc_o    (trk_rdata)
  );

endmodule

//--- test/dmem_tile_checker.sv
`timescale 1ns/10ps

module dmem_tile_checker #(
  parameter int fifo_depth_p = 4
) (
  input logic clk_i,
  input logic reset_i,
  input logic wb_cyc_i,
  input logic wb_ack_o,
  input logic local_v_i,
  input logic local_ready_o,
  input logic local_rdata_v_o,
  input logic q_yumi_i
);

  int occ_r;
  // failed assertions so far
  int fail_count = 0;

  // queue occupancy seen from its two handshakes
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      occ_r <= 0;
    end else begin
      occ_r <= occ_r + int'(local_v_i & local_ready_o) - int'(q_yumi_i);
    end
  end

  // acknowledge is a single cycle pulse
  ack_single_pulse: assert property (@(posedge clk_i) disable iff (!reset_i)
    wb_ack_o |=> !wb_ack_o)
    else begin
      fail_count++;
      $error("wb_ack_o held for more than one cycle");
    end

  // only inside a bus cycle
  ack_in_cycle: assert property (@(posedge clk_i) disable iff (!reset_i)
    wb_ack_o |-> wb_cyc_i)
    else begin
      fail_count++;
      $error("wb_ack_o outside of a wishbone cycle");
    end

  ready_when_not_full: assert property (@(posedge clk_i) disable iff (!reset_i)
    local_ready_o == (occ_r != fifo_depth_p))
    else begin
      fail_count++;
      $error("local_ready_o does not match queue occupancy");
    end

  // outputs quiet once reset has been sampled
  quiet_in_reset: assert property (@(posedge clk_i)
    !reset_i |=> (!wb_ack_o && !local_rdata_v_o && local_ready_o))
    else begin
      fail_count++;
      $error("output active during reset");
    end

endmodule

bind dmem_tile_top dmem_tile_checker #(
  .fifo_depth_p(fifo_depth_p)
) checker_i (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .wb_cyc_i        (wb_cyc_i),
  .wb_ack_o        (wb_ack_o),
  .local_v_i       (local_v_i),
  .local_ready_o   (local_ready_o),
  .local_rdata_v_o (local_rdata_v_o),
  .q_yumi_i        (q_yumi)
);

//--- test/dmem_tile_tb.sv
`timescale 1ns/10ps

module dmem_tile_tb;

  localparam int  addr_width_lp   = 8;
  localparam int  words_lp        = 2 ** addr_width_lp;
  localparam time period_lp       = 40ns;
  localparam int  rand_ops_lp     = 300;
  localparam int  burst_lp        = 12;
  // fill, reset sweep and directed phases, each op a few cycles at most
  localparam int  total_ops_lp    = 3 * words_lp + 120 + 2 * rand_ops_lp + 5 * burst_lp;
  localparam int  limit_cycles_lp = 8 * total_ops_lp + 200;

  typedef struct packed {
    logic        st;
    logic [7:0]  addr;
    logic [3:0]  mask;
    logic [31:0] data;
    logic [31:0] pc;
  } local_req_s;

  logic                 clk_i;
  logic                 reset_i;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  logic                 wb_we_i;
  logic [31:0]          wb_adr_i;
  logic [3:0]           wb_sel_i;
  logic [31:0]          wb_dat_i;
  logic                 wb_ack_o;
  logic [31:0]          wb_dat_o;
  logic                 local_v_i;
  dmem_pkg::local_op_e  local_op_i;
  logic [7:0]           local_addr_i;
  logic [3:0]           local_mask_i;
  logic [31:0]          local_data_i;
  logic [31:0]          local_pc_i;
  logic                 local_ready_o;
  logic                 local_rdata_v_o;
  logic [31:0]          local_rdata_o;

  // reference state
  logic [31:0]  shadow_mem [words_lp];
  logic [31:0]  shadow_trk [words_lp];
  local_req_s   local_q [$];
  logic         rem_exp_v = 1'b0;
  logic         rem_exp_read = 1'b0;
  logic [31:0]  rem_exp_data;
  logic         lrd_exp_v = 1'b0;
  logic [31:0]  lrd_exp_data;
  int           loads_accepted = 0;
  int           loads_seen = 0;
  logic         saw_full = 1'b0;
  int           mismatch_count = 0;
  int           other_count = 0;
  int unsigned  lcg_state = 73327;

  dmem_tile_top uut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_sel_i        (wb_sel_i),
    .wb_dat_i        (wb_dat_i),
    .wb_ack_o        (wb_ack_o),
    .wb_dat_o        (wb_dat_o),
    .local_v_i       (local_v_i),
    .local_op_i      (local_op_i),
    .local_addr_i    (local_addr_i),
    .local_mask_i    (local_mask_i),
    .local_data_i    (local_data_i),
    .local_pc_i      (local_pc_i),
    .local_ready_o   (local_ready_o),
    .local_rdata_v_o (local_rdata_v_o),
    .local_rdata_o   (local_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(period_lp / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // byte lanes enabled by the mask take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  mask);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] dmem_adr(input int idx);
    remote_map_pkg::remote_addr_u a;
    a = '0;
    a.dmem.region   = remote_map_pkg::region_dmem_gc;
    a.dmem.word_idx = 14'(idx);
    return a;
  endfunction

  function automatic logic [31:0] tracker_adr(input int idx);
    remote_map_pkg::remote_addr_u a;
    a = '0;
    a.trk.region    = remote_map_pkg::region_tracker_gc;
    a.trk.entry_idx = 14'(idx);
    return a;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    mismatch_count++;
    $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, act);
  endtask

  task automatic wb_access(input logic we, input logic [31:0] adr,
                           input logic [3:0] sel, input logic [31:0] dat);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_sel_i <= sel;
    wb_dat_i <= dat;
    do @(negedge clk_i); while (wb_ack_o !== 1'b1);
  endtask

  task automatic wb_idle();
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  task automatic local_push(input logic st, input logic [7:0] addr, input logic [3:0] mask,
                            input logic [31:0] data, input logic [31:0] pc);
    @(posedge clk_i);
    local_v_i    <= 1'b1;
    local_op_i   <= st ? dmem_pkg::local_store : dmem_pkg::local_load;
    local_addr_i <= addr;
    local_mask_i <= mask;
    local_data_i <= data;
    local_pc_i   <= pc;
    do @(negedge clk_i); while (local_ready_o !== 1'b1);
  endtask

  task automatic local_idle();
    @(posedge clk_i);
    local_v_i <= 1'b0;
  endtask

  // model state only changes on the falling edge
  task automatic drain();
    do @(posedge clk_i); while (local_q.size() != 0 || lrd_exp_v || rem_exp_v);
    repeat (2) @(posedge clk_i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model and compare, on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : compare
    local_req_s  req;
    logic        issue;
    logic        lrd_next;
    logic [31:0] adr;
    logic [7:0]  idx;
    assert (wb_ack_o === rem_exp_v)
      else report_mismatch("wb_ack_o", 32'(rem_exp_v), 32'(wb_ack_o));
    if (rem_exp_v && rem_exp_read) begin
      assert (wb_dat_o === rem_exp_data)
        else report_mismatch("remote read data", rem_exp_data, wb_dat_o);
    end
    assert (local_rdata_v_o === lrd_exp_v)
      else report_mismatch("local_rdata_v_o", 32'(lrd_exp_v), 32'(local_rdata_v_o));
    if (local_rdata_v_o === 1'b1) begin
      loads_seen++;
    end
    if (lrd_exp_v) begin
      assert (local_rdata_o === lrd_exp_data)
        else report_mismatch("local load data", lrd_exp_data, local_rdata_o);
    end
    if (local_ready_o === 1'b0) begin
      saw_full = 1'b1;
    end
    if (!reset_i) begin
      rem_exp_v = 1'b0;
      lrd_exp_v = 1'b0;
      local_q.delete();
      for (int i = 0; i < words_lp; i++) begin
        shadow_trk[i] = '0;
      end
    end else begin
      issue    = wb_cyc_i && wb_stb_i && !rem_exp_v;
      lrd_next = 1'b0;
      // remote wins, the queue head waits
      if (issue) begin
        adr = wb_adr_i;
        idx = adr[2 +: 8];
        rem_exp_read = !wb_we_i;
        if (adr[31] == remote_map_pkg::region_tracker_gc) begin
          rem_exp_data = shadow_trk[idx];
        end else if (wb_we_i) begin
          shadow_mem[idx] = merge_bytes(shadow_mem[idx], wb_dat_i, wb_sel_i);
        end else begin
          rem_exp_data = shadow_mem[idx];
        end
      end else if (local_q.size() != 0) begin
        req = local_q.pop_front();
        if (req.st) begin
          shadow_mem[req.addr] = merge_bytes(shadow_mem[req.addr], req.data, req.mask);
          shadow_trk[req.addr] = req.pc;
        end else begin
          lrd_next     = 1'b1;
          lrd_exp_data = shadow_mem[req.addr];
        end
      end
      // accepted now, at the head next cycle
      if (local_v_i && local_ready_o) begin
        local_q.push_back({local_op_i == dmem_pkg::local_store, local_addr_i,
                           local_mask_i, local_data_i, local_pc_i});
        if (local_op_i == dmem_pkg::local_load) begin
          loads_accepted++;
        end
      end
      rem_exp_v = issue;
      lrd_exp_v = lrd_next;
    end
  end

  initial begin : watchdog
    #(period_lp * limit_cycles_lp);
    $display("timeout: DUT did not finish within %0d cycles", limit_cycles_lp);
    $display("Simulation finished: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int unsigned r;
    reset_i      = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_sel_i     = '0;
    wb_dat_i     = '0;
    local_v_i    = 1'b0;
    local_op_i   = dmem_pkg::local_load;
    local_addr_i = '0;
    local_mask_i = '0;
    local_data_i = '0;
    local_pc_i   = '0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b1;

    // fill every word so no read returns unknown data
    for (int i = 0; i < words_lp; i++) begin
      wb_access(1'b1, dmem_adr(i), 4'hf, lcg_next());
    end
    // masked remote writes then reads
    for (int i = 0; i < 32; i++) begin
      r = lcg_next();
      wb_access(1'b1, dmem_adr(r[7:0]), r[11:8], lcg_next());
      wb_access(1'b0, dmem_adr(r[7:0]), 4'hf, 32'h0);
    end
    wb_idle();

    // local stores, seen remotely and by local loads
    for (int i = 0; i < 8; i++) begin
      local_push(1'b1, 8'(16 + i), 4'hf, lcg_next(), 32'h1000 + 4 * i);
    end
    for (int i = 0; i < 8; i++) begin
      local_push(1'b0, 8'(16 + i), 4'hf, 32'h0, 32'h1100);
    end
    local_idle();
    drain();
    for (int i = 0; i < 8; i++) begin
      wb_access(1'b0, dmem_adr(16 + i), 4'hf, 32'h0);
    end

    // tracker: written words, untouched words, remote store leaves it alone
    for (int i = 12; i < 28; i++) begin
      wb_access(1'b0, tracker_adr(i), 4'hf, 32'h0);
    end
    wb_access(1'b1, dmem_adr(18), 4'hf, 32'h5a5a_0018);
    wb_access(1'b0, tracker_adr(18), 4'hf, 32'h0);
    wb_idle();
    drain();

    // random mixed traffic on a small window so requests collide
    fork
      for (int i = 0; i < rand_ops_lp; i++) begin
        r = lcg_next();
        if (r[5]) begin
          wb_idle();
        end else if (r[3:1] == 3'd0) begin
          wb_access(1'b0, tracker_adr(r[11:8]), 4'hf, 32'h0);
        end else begin
          wb_access(r[0], dmem_adr(r[11:8]), r[15:12], lcg_next());
        end
      end
      for (int i = 0; i < rand_ops_lp; i++) begin
        r = lcg_next();
        if (r[6]) begin
          local_idle();
        end else begin
          local_push(r[0], 8'(r[11:8]), r[15:12], lcg_next(), 32'h2000_0000 + 4 * i);
        end
      end
    join
    wb_idle();
    local_idle();
    drain();

    // local burst against back to back remote reads
    saw_full = 1'b0;
    fork
      for (int i = 0; i < 2 * burst_lp; i++) begin
        wb_access(1'b0, dmem_adr(i), 4'hf, 32'h0);
      end
      for (int i = 0; i < burst_lp; i++) begin
        local_push(i[0], 8'(i), 4'hf, lcg_next(), 32'h3000 + 4 * i);
      end
    join
    wb_idle();
    local_idle();
    drain();
    // burst stores landed, data and pc both
    for (int i = 0; i < burst_lp; i++) begin
      wb_access(1'b0, dmem_adr(i), 4'hf, 32'h0);
      wb_access(1'b0, tracker_adr(i), 4'hf, 32'h0);
    end
    wb_idle();
    drain();
    assert (saw_full)
      else begin
        other_count++;
        $display("local_ready_o never dropped during the local burst");
      end

    // reset again, tracker must read back as zero
    @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b1;
    for (int i = 0; i < words_lp; i++) begin
      wb_access(1'b0, tracker_adr(i), 4'hf, 32'h0);
    end
    wb_idle();
    drain();

    assert (loads_seen == loads_accepted)
      else begin
        other_count++;
        $display("%0d local loads accepted but %0d returned", loads_accepted, loads_seen);
      end
    // protocol assertion failures from the bound checker
    other_count += uut.checker_i.fail_count;
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
source/dmem_pkg.sv
source/remote_map_pkg.sv
source/wb_remote_port.sv
source/local_req_fifo.sv
source/dmem_arbiter.sv
source/dmem_bank.sv
source/dmem_write_tracker.sv
source/dmem_tile_top.sv
test/dmem_tile_checker.sv
test/dmem_tile_tb.sv

//--- Bender.yml
package:
  name: dmem_tile

sources:
  - source/dmem_pkg.sv
  - source/remote_map_pkg.sv
  - source/wb_remote_port.sv
  - source/local_req_fifo.sv
  - source/dmem_arbiter.sv
  - source/dmem_bank.sv
  - source/dmem_write_tracker.sv
  - source/dmem_tile_top.sv
  - target: test
    files:
      - test/dmem_tile_checker.sv
      - test/dmem_tile_tb.sv
